/* src/exec_defines.svh */
// Width and trap cause macros shared by the execute stage packages and RTL
// Include in any file that sizes a data word or builds a trap cause
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Widths --------------------
`define EXEC_XLEN          32  // Data word width
`define EXEC_REG_ADDR_W    5   // Register address width, also the cause width
`define EXEC_SHAMT_W       5   // Shift amount taken from the low bits of rhs

// Trap causes ---------------
// These ride in the s3 destination field when s3_trap is set
`define EXEC_CAUSE_IALIGN  0   // Jump target not word aligned
`define EXEC_CAUSE_EBREAK  3   // Breakpoint
`define EXEC_CAUSE_ECALL   11  // Environment call from M mode

`endif

/* src/exec_op_pkg.sv */
// Operation encodings that decode hands to the execute stage
// Import by wildcard wherever an ALU, CFU or writeback select field is carried
`include "exec_defines.svh"

package exec_op_pkg;

    // ALU --------------------
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,   // Result forced to zero
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,   // Shifts use rhs low bits only
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,   // Signed compare
        ALU_SLTU = 4'd10   // Unsigned compare
    } alu_op_t;

    // Control flow -----------
    typedef enum logic [3:0] {
        CFU_NONE   = 4'd0,
        CFU_BEQ    = 4'd1,
        CFU_BNE    = 4'd2,
        CFU_BLT    = 4'd3,
        CFU_BGE    = 4'd4,
        CFU_BLTU   = 4'd5,
        CFU_BGEU   = 4'd6,
        CFU_JAL    = 4'd7,
        CFU_JALR   = 4'd8,
        CFU_MRET   = 4'd9,   // Return to mepc
        CFU_ECALL  = 4'd10,
        CFU_EBREAK = 4'd11
    } cfu_op_t;

    typedef enum logic {
        WB_ALU = 1'b0,   // Write ALU result
        WB_NPC = 1'b1    // Write link address
    } wb_sel_t;

endpackage

/* src/exec_stage_pkg.sv */
// Data types carried between decode, execute and writeback
// Import by wildcard in modules that move words, register addresses or causes
`include "exec_defines.svh"

package exec_stage_pkg;

    // Basic words ------------
    typedef logic [`EXEC_XLEN-1:0]       word_t;       // One data word
    typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;   // Register file index
    typedef logic [`EXEC_REG_ADDR_W-1:0] trap_cause_t; // Same width as rd

    // Destination field ------
    // Writeback reads this as rd for a normal instruction. When s3_trap is
    // set the same bits hold the cause code for the trap handler.
    typedef union packed {
        reg_addr_t   rd;      // Valid while s3_trap is low
        trap_cause_t cause;   // Valid while s3_trap is high
    } s3_dest_u;

endpackage

/* src/exec_alu.sv */
// Combinational ALU for the execute stage
// Also exposes the raw sum and compare flags for branch resolution
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
(
    input  word_t   lhs,       // Left operand
    input  word_t   rhs,       // Right operand
    input  alu_op_t op,        // Operation select
    output word_t   result,    // Selected result
    output word_t   add_out,   // lhs + rhs, always valid
    output logic    cmp_eq,    // lhs == rhs
    output logic    cmp_lt,    // lhs <  rhs signed
    output logic    cmp_ltu    // lhs <  rhs unsigned
);

    // Shared datapath --------
    logic [`EXEC_SHAMT_W-1:0] shamt;     // Shift distance
    word_t                    sum;       // Adder
    word_t                    diff;      // Subtractor
    word_t                    sra_out;   // Arithmetic right shift

    assign sum     = lhs + rhs;
    assign diff    = lhs - rhs;
    assign shamt   = rhs[`EXEC_SHAMT_W-1:0];
    assign sra_out = word_t'($signed(lhs) >>> shamt);

    assign add_out = sum;
    assign cmp_eq  = (lhs == rhs);
    assign cmp_lt  = ($signed(lhs) < $signed(rhs));
    assign cmp_ltu = (lhs < rhs);

    // Result select ----------
    always_comb begin
        case (op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = lhs & rhs;
            ALU_OR:   result = lhs | rhs;
            ALU_XOR:  result = lhs ^ rhs;
            ALU_SLL:  result = lhs << shamt;
            ALU_SRL:  result = lhs >> shamt;
            ALU_SRA:  result = sra_out;
            ALU_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, cmp_lt};    // Zero extend flag
            ALU_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, cmp_ltu};
            default:  result = '0;                                  // ALU_NONE
        endcase
    end

endmodule

/* src/exec_cfu.sv */
// Control flow unit: resolves branches and jumps, requests the redirect
// from fetch over cf_valid/cf_ack and flags ecall, ebreak and misaligned
// targets. Holds the request until acked, then waits for s2 to advance.
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_cfu
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
(
    input  logic        g_clk,        // Clock
    input  logic        g_resetn,     // Sync reset, active low
    input  logic        s2_valid,     // Instruction present in s2
    input  logic        s2_accept,    // s2 instruction moves on this edge
    input  logic        s2_trap,      // Decode already raised a trap
    input  cfu_op_t     op,           // Control flow operation
    input  word_t       pc,           // Instruction address
    input  word_t       rs1,          // Base for jalr
    input  word_t       imm,          // Offset
    input  word_t       csr_mepc,     // Return address for mret
    input  logic        cmp_eq,       // ALU compare flags
    input  logic        cmp_lt,
    input  logic        cmp_ltu,
    input  logic        cf_ack,       // Fetch took the redirect
    output logic        cf_valid,     // Redirect request
    output word_t       cf_target,    // Redirect address
    output logic        finished,     // Nothing left to wait for
    output logic        trap_raise,   // Trap from this unit
    output trap_cause_t trap_cause    // Its cause
);

    logic  cf_done;     // Request already acked for this instruction
    logic  taken;       // Branch condition true or unconditional jump
    logic  cf_needed;   // Fetch must be redirected
    logic  align_err;   // Target bit 1 set
    word_t jalr_sum;
    word_t target;

    assign jalr_sum = rs1 + imm;

    // Resolution -------------
    always_comb begin
        taken  = 1'b0;
        target = pc + imm;                             // Branches and jal
        case (op)
            CFU_BEQ:  taken = cmp_eq;
            CFU_BNE:  taken = !cmp_eq;
            CFU_BLT:  taken = cmp_lt;
            CFU_BGE:  taken = !cmp_lt;
            CFU_BLTU: taken = cmp_ltu;
            CFU_BGEU: taken = !cmp_ltu;
            CFU_JAL:  taken = 1'b1;
            CFU_JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[`EXEC_XLEN-1:1], 1'b0};   // Clear bit 0
            end
            CFU_MRET: begin
                taken  = 1'b1;
                target = csr_mepc;
            end
            default:  taken = 1'b0;                    // ecall, ebreak, none
        endcase
    end

    assign align_err = taken && target[1];
    assign cf_needed = taken && !s2_trap && !align_err;

    // Fetch request ----------
    assign cf_valid  = s2_valid && cf_needed && !cf_done;
    assign cf_target = target;
    assign finished  = !cf_needed || cf_done || cf_ack;

    // Traps ------------------
    assign trap_raise = (op == CFU_ECALL) || (op == CFU_EBREAK) || align_err;

    always_comb begin
        if (op == CFU_ECALL) begin
            trap_cause = trap_cause_t'(`EXEC_CAUSE_ECALL);
        end else if (op == CFU_EBREAK) begin
            trap_cause = trap_cause_t'(`EXEC_CAUSE_EBREAK);
        end else begin
            trap_cause = trap_cause_t'(`EXEC_CAUSE_IALIGN);  // Only other source
        end
    end

    // Remember the ack while writeback stalls the instruction in s2
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else if (s2_accept) begin
            cf_done <= 1'b0;                           // Next instruction starts fresh
        end else if (cf_valid && cf_ack) begin
            cf_done <= 1'b1;
        end
    end

endmodule

/* src/exec_wb_reg.sv */
// Execute to writeback stage register
// Joins the s2/s3 handshakes, picks the writeback data and packs rd or the
// trap cause into the shared destination field
`timescale 1ns/1ps

module exec_wb_reg
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
(
    input  logic        g_clk,            // Clock
    input  logic        g_resetn,         // Sync reset, active low
    input  logic        s2_valid,         // Decode has an instruction
    input  logic        s2_flush,         // Drop what would enter s3
    input  logic        s3_ready,         // Writeback can take one
    input  logic        cfu_finished,     // CFU not holding the instruction
    input  word_t       pc,
    input  word_t       npc,              // Link address
    input  word_t       alu_result,
    input  wb_sel_t     wb_sel,           // Writeback data source
    input  logic        wb_en,            // Instruction writes rd
    input  reg_addr_t   rd,
    input  cfu_op_t     cfu_op,
    input  logic        s2_trap,          // Decode trap
    input  trap_cause_t s2_trap_cause,
    input  logic        cfu_trap,         // CFU trap
    input  trap_cause_t cfu_trap_cause,
    output logic        s2_ready,         // Execute takes the instruction
    output logic        s3_valid,         // Offered to writeback
    output logic        s3_full,          // s3 holds an instruction
    output word_t       s3_pc,
    output word_t       s3_wdata,
    output s3_dest_u    s3_dest,          // rd, or cause when trapping
    output cfu_op_t     s3_cfu_op,
    output logic        s3_wen,
    output logic        s3_trap
);

    logic     s3_load;   // Payload capture enable
    logic     n_trap;
    word_t    n_wdata;
    s3_dest_u n_dest;

    // Handshake --------------
    assign s3_valid = s2_valid && cfu_finished;
    assign s2_ready = s3_ready && cfu_finished;
    assign s3_load  = s3_valid && s3_ready && !s2_flush;

    assign n_trap   = s2_trap || cfu_trap;
    assign n_wdata  = (wb_sel == WB_NPC) ? npc : alu_result;

    always_comb begin
        n_dest.rd = rd;
        if (s2_trap) begin
            n_dest.cause = s2_trap_cause;      // Decode fault wins
        end else if (cfu_trap) begin
            n_dest.cause = cfu_trap_cause;
        end
    end

    // Control ----------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || s2_flush) begin
            s3_full <= 1'b0;
            s3_trap <= 1'b0;
        end else if (s3_ready) begin           // Old entry retires
            s3_full <= s3_valid;
            s3_trap <= s3_valid && n_trap;
        end
    end

    // Payload ----------------
    always_ff @(posedge g_clk) begin
        if (s3_load) begin
            s3_pc     <= pc;
            s3_wdata  <= n_wdata;
            s3_dest   <= n_dest;
            s3_cfu_op <= cfu_op;
            s3_wen    <= wb_en && !n_trap;     // Trapping instr never writes
        end
    end

endmodule

/* src/exec_stage.sv */
// Execute stage top: ALU, control flow unit and the s3 stage register
// Decode drives the s2 side, fetch answers cf requests, writeback drains s3
`timescale 1ns/1ps

module exec_stage
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
(
    input  logic        g_clk,           // Clock
    input  logic        g_resetn,        // Sync reset, active low
    input  logic        s2_valid,        // Decode to execute
    output logic        s2_ready,
    input  logic        s2_flush,        // Kill the instruction entering s3
    input  logic        s2_trap,         // Decode raised a trap
    input  trap_cause_t s2_trap_cause,
    input  word_t       s2_pc,
    input  word_t       s2_npc,
    input  word_t       s2_rs1_data,     // jalr base
    input  word_t       s2_alu_lhs,
    input  word_t       s2_alu_rhs,
    input  word_t       s2_imm,
    input  reg_addr_t   s2_rd,
    input  alu_op_t     s2_alu_op,
    input  cfu_op_t     s2_cfu_op,
    input  wb_sel_t     s2_wb_sel,
    input  logic        s2_wb_en,
    input  word_t       csr_mepc,        // mret target
    output logic        cf_valid,        // Redirect to fetch
    input  logic        cf_ack,
    output word_t       cf_target,
    output logic        s3_valid,        // Execute to writeback
    input  logic        s3_ready,
    output logic        s3_full,
    output word_t       s3_pc,
    output word_t       s3_wdata,
    output s3_dest_u    s3_dest,
    output cfu_op_t     s3_cfu_op,
    output logic        s3_wen,
    output logic        s3_trap
);

    // Internal wires ---------
    word_t       alu_result;
    logic        alu_cmp_eq;
    logic        alu_cmp_lt;
    logic        alu_cmp_ltu;
    logic        cfu_finished;
    logic        cfu_trap_raise;
    trap_cause_t cfu_trap_cause;
    logic        s2_accept;          // s2 instruction leaves this edge

    assign s2_accept = s2_valid && s2_ready;

    exec_alu i_alu (
        .lhs     (s2_alu_lhs),
        .rhs     (s2_alu_rhs),
        .op      (s2_alu_op),
        .result  (alu_result),
        .add_out (),                 // Targets use the CFU adders
        .cmp_eq  (alu_cmp_eq),
        .cmp_lt  (alu_cmp_lt),
        .cmp_ltu (alu_cmp_ltu)
    );

    exec_cfu i_cfu (
        .g_clk, .g_resetn, .s2_valid, .s2_accept, .s2_trap,
        .op         (s2_cfu_op),
        .pc         (s2_pc),
        .rs1        (s2_rs1_data),
        .imm        (s2_imm),
        .csr_mepc,
        .cmp_eq     (alu_cmp_eq),
        .cmp_lt     (alu_cmp_lt),
        .cmp_ltu    (alu_cmp_ltu),
        .cf_ack, .cf_valid, .cf_target,
        .finished   (cfu_finished),
        .trap_raise (cfu_trap_raise),
        .trap_cause (cfu_trap_cause)
    );

    exec_wb_reg i_wb_reg (
        .g_clk, .g_resetn, .s2_valid, .s2_flush, .s3_ready,
        .cfu_finished,
        .pc             (s2_pc),
        .npc            (s2_npc),
        .alu_result,
        .wb_sel         (s2_wb_sel),
        .wb_en          (s2_wb_en),
        .rd             (s2_rd),
        .cfu_op         (s2_cfu_op),
        .s2_trap, .s2_trap_cause,
        .cfu_trap       (cfu_trap_raise),
        .cfu_trap_cause,
        .s2_ready, .s3_valid, .s3_full, .s3_pc, .s3_wdata,
        .s3_dest, .s3_cfu_op, .s3_wen, .s3_trap
    );

endmodule

/* verification/exec_stage_props.sv */
// Concurrent checks on the execute stage handshakes and reset state
// Bound into every exec_stage instance by the bind at the end of this file
`timescale 1ns/1ps

module exec_stage_props
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
(
    input logic  g_clk,
    input logic  g_resetn,
    input logic  s2_valid,
    input logic  cf_valid,
    input logic  cf_ack,
    input word_t cf_target,
    input logic  s3_valid,
    input logic  s3_full
);

    // Fetch request ----------
    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_valid && !cf_ack |=> cf_valid && $stable(cf_target))
        else $error("cf request dropped or changed before cf_ack");

    // Reset state ------------
    a_reset_clear: assert property (@(posedge g_clk)
        !g_resetn |=> !s3_full && !cf_valid)
        else $error("s3_full or cf_valid high after reset");

    // s3 fills only from an instruction offered by s2
    a_s3_from_s2: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(s3_full) |-> $past(s2_valid && s3_valid))
        else $error("s3_full rose without an s2 instruction on offer");

endmodule

bind exec_stage exec_stage_props i_props (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .s2_valid  (s2_valid),
    .cf_valid  (cf_valid),
    .cf_ack    (cf_ack),
    .cf_target (cf_target),
    .s3_valid  (s3_valid),
    .s3_full   (s3_full)
);

/* verification/exec_stage_tb.sv */
// Table driven testbench for the execute stage
// Feeds decode entries, models fetch acks and writeback stalls from an LFSR,
// checks every entry in s3 the cycle after it is accepted
`timescale 1ns/1ps

module exec_stage_tb
    import exec_op_pkg::*;
    import exec_stage_pkg::*;
();

    typedef struct packed {
        logic        flush;        // Assert s2_flush with this entry
        logic        trap;         // Decode trap
        trap_cause_t cause;
        word_t       pc;
        word_t       rs1;
        word_t       lhs;
        word_t       rhs;
        word_t       imm;
        word_t       mepc;
        reg_addr_t   rd;
        alu_op_t     alu_op;
        cfu_op_t     cfu_op;
        wb_sel_t     wb_sel;
        logic        wb_en;
        word_t       exp_wdata;    // Expected results
        s3_dest_u    exp_dest;
        logic        exp_trap;
        logic        exp_cf;       // One fetch redirect expected
        word_t       exp_target;
    } entry_t;

    // DUT signals ------------
    logic        g_clk         = 1'b0;
    logic        g_resetn      = 1'b0;
    logic        s2_valid      = 1'b0;
    logic        s2_flush      = 1'b0;
    logic        s2_trap       = 1'b0;
    trap_cause_t s2_trap_cause = '0;
    word_t       s2_pc         = '0;
    word_t       s2_npc        = '0;
    word_t       s2_rs1_data   = '0;
    word_t       s2_alu_lhs    = '0;
    word_t       s2_alu_rhs    = '0;
    word_t       s2_imm        = '0;
    reg_addr_t   s2_rd         = '0;
    alu_op_t     s2_alu_op     = ALU_NONE;
    cfu_op_t     s2_cfu_op     = CFU_NONE;
    wb_sel_t     s2_wb_sel     = WB_ALU;
    logic        s2_wb_en      = 1'b0;
    word_t       csr_mepc      = '0;
    logic        cf_ack        = 1'b0;
    logic        s3_ready      = 1'b0;
    logic        s2_ready;
    logic        cf_valid;
    word_t       cf_target;
    logic        s3_valid;
    logic        s3_full;
    word_t       s3_pc;
    word_t       s3_wdata;
    s3_dest_u    s3_dest;
    cfu_op_t     s3_cfu_op;
    logic        s3_wen;
    logic        s3_trap;

    // Bench state ------------
    entry_t      tbl[$];                    // Stimulus and expected values
    int          accepted_q[$];             // Entries taken by s2, awaiting check
    logic        offer_q[$];                // s3_valid seen at each accept
    logic [31:0] lfsr_state = 32'hf54c8ef0;
    logic [1:0]  ack_hold   = 2'd0;         // Cycles left in cf_ack stretch
    logic [1:0]  rdy_hold   = 2'd0;         // Cycles left in s3_ready stretch
    int          cf_count   = 0;            // Acked fetch redirects
    int          cf_base    = 0;
    int          cf_seen;
    word_t       cf_last_target = '0;
    int          err_count  = 0;
    int          check_count = 0;
    int          checked    = 0;
    int          chk_idx;
    logic        chk_offer;
    entry_t      chk_e;

    always #10 g_clk = ~g_clk;              // 20 ns period

    exec_stage i_dut (.*);

    // Random source ----------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_bits2(output logic [1:0] v);
        v = 2'b00;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[0], lfsr_state[0]};
        end
    endtask

    // Table builders ---------
    task automatic add_alu(input alu_op_t op, input word_t lhs, input word_t rhs,
                           input reg_addr_t rd, input word_t exp_wdata);
        entry_t e;
        e = '0;
        e.pc        = 32'h0000_0080 + word_t'(tbl.size() * 4);
        e.lhs       = lhs;
        e.rhs       = rhs;
        e.rd        = rd;
        e.alu_op    = op;
        e.wb_en     = 1'b1;
        e.exp_wdata = exp_wdata;
        e.exp_dest.rd = rd;
        tbl.push_back(e);
    endtask

    // Branches write nothing and leave wdata at the ALU_NONE zero
    task automatic add_branch(input cfu_op_t op, input word_t lhs, input word_t rhs,
                              input word_t pc, input word_t imm,
                              input logic exp_cf, input word_t exp_target);
        entry_t e;
        e = '0;
        e.cfu_op     = op;
        e.lhs        = lhs;
        e.rhs        = rhs;
        e.pc         = pc;
        e.imm        = imm;
        e.exp_cf     = exp_cf;
        e.exp_target = exp_target;
        tbl.push_back(e);
    endtask

    // Jumps, mret and traps with base driving both rs1 and mepc
    // Link data is always pc plus 4
    task automatic add_flow(input cfu_op_t op, input word_t pc, input word_t base,
                            input word_t imm, input reg_addr_t rd,
                            input logic dec_trap, input trap_cause_t dec_cause,
                            input logic exp_cf, input word_t exp_target,
                            input logic exp_trap, input trap_cause_t exp_cause);
        entry_t e;
        e = '0;
        e.cfu_op     = op;
        e.pc         = pc;
        e.rs1        = base;
        e.mepc       = base;
        e.imm        = imm;
        e.rd         = rd;
        e.wb_sel     = WB_NPC;
        e.wb_en      = (rd != '0);
        e.trap       = dec_trap;
        e.cause      = dec_cause;
        e.exp_wdata  = pc + 32'd4;
        e.exp_cf     = exp_cf;
        e.exp_target = exp_target;
        e.exp_trap   = exp_trap;
        if (exp_trap) begin
            e.exp_dest.cause = exp_cause;
        end else begin
            e.exp_dest.rd = rd;
        end
        tbl.push_back(e);
    endtask

    task automatic build_table();
        add_alu(ALU_ADD,  32'h0000_1234, 32'h0000_0f0f, 5'd1,  32'h0000_2143);
        add_alu(ALU_SUB,  32'h0000_0005, 32'h0000_0007, 5'd2,  32'hffff_fffe);
        add_alu(ALU_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 5'd3,  32'h00f0_1200);
        add_alu(ALU_OR,   32'hf000_000f, 32'h0000_f0f0, 5'd4,  32'hf000_f0ff);
        add_alu(ALU_XOR,  32'haaaa_5555, 32'hffff_0000, 5'd5,  32'h5555_5555);
        add_alu(ALU_SLL,  32'h0000_0003, 32'h0000_0024, 5'd6,  32'h0000_0030);  // Shamt 4
        add_alu(ALU_SRL,  32'h8000_0000, 32'h0000_001f, 5'd7,  32'h0000_0001);
        add_alu(ALU_SRA,  32'h8000_0000, 32'h0000_0004, 5'd8,  32'hf800_0000);
        add_alu(ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 5'd9,  32'h0000_0001);
        add_alu(ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 5'd10, 32'h0000_0000);
        // Each branch once with its condition true and once false
        add_branch(CFU_BEQ,  32'd5, 32'd5, 32'h200, 32'h10, 1'b1, 32'h210);
        add_branch(CFU_BNE,  32'd5, 32'd5, 32'h204, 32'h10, 1'b0, 32'h0);
        add_branch(CFU_BLT,  32'hffff_fff0, 32'd3, 32'h208, 32'hffff_fff8, 1'b1, 32'h200);
        add_branch(CFU_BGE,  32'hffff_fff0, 32'd3, 32'h20c, 32'h10, 1'b0, 32'h0);
        add_branch(CFU_BLTU, 32'hffff_fff0, 32'd3, 32'h210, 32'h10, 1'b0, 32'h0);
        add_branch(CFU_BGEU, 32'hffff_fff0, 32'd3, 32'h300, 32'h100, 1'b1, 32'h400);
        add_branch(CFU_BEQ,  32'd5, 32'd6, 32'h400, 32'h20, 1'b0, 32'h0);
        add_branch(CFU_BNE,  32'd5, 32'd6, 32'h404, 32'h20, 1'b1, 32'h424);
        add_branch(CFU_BLT,  32'd3, 32'hffff_fff0, 32'h408, 32'h20, 1'b0, 32'h0);
        add_branch(CFU_BGE,  32'd3, 32'hffff_fff0, 32'h40c, 32'h20, 1'b1, 32'h42c);
        add_branch(CFU_BLTU, 32'd3, 32'hffff_fff0, 32'h410, 32'h20, 1'b1, 32'h430);
        add_branch(CFU_BGEU, 32'd3, 32'hffff_fff0, 32'h414, 32'h20, 1'b0, 32'h0);
        add_flow(CFU_JAL,  32'h1000, 32'h0,    32'h800, 5'd1, 1'b0, 5'd0,
                 1'b1, 32'h1800, 1'b0, 5'd0);
        add_flow(CFU_JALR, 32'h1004, 32'h2001, 32'h4,   5'd5, 1'b0, 5'd0,
                 1'b1, 32'h2004, 1'b0, 5'd0);                 // Bit 0 cleared
        add_flow(CFU_MRET, 32'h1008, 32'h400,  32'h0,   5'd0, 1'b0, 5'd0,
                 1'b1, 32'h400,  1'b0, 5'd0);
        add_flow(CFU_ECALL,  32'h100c, 32'h0, 32'h0, 5'd7, 1'b0, 5'd0, 1'b0, 32'h0, 1'b1, 5'd11);
        add_flow(CFU_EBREAK, 32'h1010, 32'h0, 32'h0, 5'd7, 1'b0, 5'd0, 1'b0, 32'h0, 1'b1, 5'd3);
        add_flow(CFU_JAL,  32'h1014, 32'h0,    32'hfe,  5'd3, 1'b0, 5'd0,
                 1'b0, 32'h0, 1'b1, 5'd0);                    // Target 0x1112
        add_flow(CFU_JALR, 32'h1018, 32'h3000, 32'h3,   5'd4, 1'b0, 5'd0,
                 1'b0, 32'h0, 1'b1, 5'd0);                    // Target 0x3002
        add_flow(CFU_JAL,  32'h101c, 32'h0, 32'h800, 5'd1, 1'b1, 5'd2, 1'b0, 32'h0, 1'b1, 5'd2);
        add_flow(CFU_ECALL, 32'h1020, 32'h0, 32'h0, 5'd0, 1'b1, 5'd1, 1'b0, 32'h0, 1'b1, 5'd1);
        add_alu(ALU_ADD, 32'd1, 32'd2, 5'd11, 32'd3);
        tbl[tbl.size() - 1].flush = 1'b1;                     // Never reaches s3
        add_alu(ALU_ADD, 32'd1, 32'd1, 5'd12, 32'd2);
    endtask

    task automatic apply_entry(input entry_t e);
        s2_valid      <= 1'b1;
        s2_flush      <= e.flush;
        s2_trap       <= e.trap;
        s2_trap_cause <= e.cause;
        s2_pc         <= e.pc;
        s2_npc        <= e.pc + 32'd4;
        s2_rs1_data   <= e.rs1;
        s2_alu_lhs    <= e.lhs;
        s2_alu_rhs    <= e.rhs;
        s2_imm        <= e.imm;
        s2_rd         <= e.rd;
        s2_alu_op     <= e.alu_op;
        s2_cfu_op     <= e.cfu_op;
        s2_wb_sel     <= e.wb_sel;
        s2_wb_en      <= e.wb_en;
        csr_mepc      <= e.mepc;
    endtask

    // Checks -----------------
    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t: entry %0d %s is %h, expected %h",
                     $time, chk_idx, what, got, exp);
        end
    endtask

    task automatic check_dest(input s3_dest_u got, input s3_dest_u exp, input logic is_trap);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t: entry %0d s3_dest.%s is %0d, expected %0d", $time,
                     chk_idx, is_trap ? "cause" : "rd", got.rd, exp.rd);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t: entry %0d %s is %b, expected %b",
                     $time, chk_idx, what, got, exp);
        end
    endtask

    task automatic check_op(input cfu_op_t got, input cfu_op_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t: entry %0d s3_cfu_op is %s, expected %s",
                     $time, chk_idx, got.name(), exp.name());
        end
    endtask

    // Fetch ack and writeback ready models driven from the LFSR
    always @(posedge g_clk) begin
        if (cf_valid && cf_ack) begin
            cf_count++;                      // Redirect taken by fetch
            cf_last_target = cf_target;
        end
        if (!g_resetn) begin
            cf_ack   <= 1'b0;
            s3_ready <= 1'b0;
        end else begin
            if (ack_hold == 2'd0) begin
                cf_ack <= !cf_ack;           // New stretch
                draw_bits2(ack_hold);
            end else begin
                ack_hold = ack_hold - 2'd1;
            end
            if (rdy_hold == 2'd0) begin
                s3_ready <= !s3_ready;
                draw_bits2(rdy_hold);
            end else begin
                rdy_hold = rdy_hold - 2'd1;
            end
        end
    end

    // s3 holds the accepted entry until the next edge
    always @(negedge g_clk) begin
        if (accepted_q.size() != 0) begin
            chk_idx   = accepted_q.pop_front();
            chk_offer = offer_q.pop_front();
            chk_e     = tbl[chk_idx];
            cf_seen   = cf_count - cf_base;  // Acks since previous accept
            cf_base   = cf_count;
            checked++;
            check_bit("s3_valid at accept", chk_offer, 1'b1);
            check_word("cf request count", word_t'(cf_seen), word_t'(chk_e.exp_cf));
            if (chk_e.exp_cf) begin
                check_word("cf_target", cf_last_target, chk_e.exp_target);
            end
            if (chk_e.flush) begin
                check_bit("s3_full after flush", s3_full, 1'b0);
            end else begin
                check_bit("s3_full", s3_full, 1'b1);
                check_word("s3_pc", s3_pc, chk_e.pc);
                check_word("s3_wdata", s3_wdata, chk_e.exp_wdata);
                check_dest(s3_dest, chk_e.exp_dest, chk_e.exp_trap);
                check_op(s3_cfu_op, chk_e.cfu_op);
                check_bit("s3_trap", s3_trap, chk_e.exp_trap);
                check_bit("s3_wen", s3_wen, chk_e.wb_en && !chk_e.exp_trap);
            end
        end
    end

    // Main sequence ----------
    initial begin
        build_table();
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);
        foreach (tbl[i]) begin
            apply_entry(tbl[i]);             // Held until s2 takes it
            @(posedge g_clk);
            while (!(s2_valid && s2_ready)) @(posedge g_clk);
            accepted_q.push_back(i);
            offer_q.push_back(s3_valid);
        end
        s2_valid <= 1'b0;
        s2_flush <= 1'b0;
        repeat (2) @(posedge g_clk);         // Let the last check run
        $display("Summary: %0d checks, %0d errors, %0d of %0d entries accepted",
                 check_count, err_count, checked, tbl.size());
        if (err_count == 0 && checked == tbl.size()) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog allows ten cycles per entry plus reset and drain
    initial begin
        #1;
        repeat (tbl.size() * 10 + 16 + 8) @(posedge g_clk);
        $display("Watchdog expired before all table entries were accepted");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* exec_stage.f */
+incdir+src
src/exec_op_pkg.sv
src/exec_stage_pkg.sv
src/exec_alu.sv
src/exec_cfu.sv
src/exec_wb_reg.sv
src/exec_stage.sv
verification/exec_stage_props.sv
verification/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exec_stage_tb -f exec_stage.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vexec_stage_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$log"; then
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' "$log"; then
    echo "No pass line found in $log"
    exit 1
fi
exit 0
